//--- source/memCtrlPkg.sv
`default_nettype none

package memCtrlPkg;

    localparam int dataWidth = 32;
    localparam int beatsPerLine = 4;
    localparam int cacheAddrWidth = 8;
    localparam int extAddrWidth = 32;
    localparam int numSlots = 4;
    localparam int idWidth = 2;
    localparam int numClients = 2;

    // beat index within a line, and progress counters that can reach a full line
    localparam int beatIdxWidth = $clog2(beatsPerLine);
    localparam int progWidth = beatIdxWidth + 1;
    localparam logic [progWidth-1:0] progFull = progWidth'(beatsPerLine);

    // AXI burst fields
    localparam logic [7:0] burstLen = 8'(beatsPerLine - 1);
    localparam logic [1:0] burstIncr = 2'b01;

    // byte address of a line start has its low bits cleared
    localparam int lineBytes = beatsPerLine * dataWidth / 8;
    localparam logic [extAddrWidth-1:0] lineAlignMask = ~(extAddrWidth'(lineBytes - 1));

    typedef enum logic [1:0] {
        cmdNone,
        cmdFill,
        cmdWriteback,
        cmdReplace
    } memCmd;

endpackage

`default_nettype wire

//--- source/transferTable.sv
`timescale 1ns/100ps
`default_nettype none

module transferTable (
    input  wire clk,
    input  wire rst,
    input  wire memCtrlPkg::memCmd reqCmd [memCtrlPkg::numClients-1:0],
    input  wire [memCtrlPkg::cacheAddrWidth-1:0] reqCacheAddr [memCtrlPkg::numClients-1:0],
    input  wire [memCtrlPkg::extAddrWidth-1:0] reqExtAddr [memCtrlPkg::numClients-1:0],
    input  wire [memCtrlPkg::extAddrWidth-1:0] reqOldAddr [memCtrlPkg::numClients-1:0],
    output logic [memCtrlPkg::numClients-1:0] stall,
    output logic [memCtrlPkg::numSlots-1:0] slotBusy,
    output logic arvalid,
    input  wire arready,
    output logic [memCtrlPkg::idWidth-1:0] arid,
    output logic [memCtrlPkg::extAddrWidth-1:0] araddr,
    output logic [7:0] arlen,
    output logic [1:0] arburst,
    output logic awvalid,
    input  wire awready,
    output logic [memCtrlPkg::idWidth-1:0] awid,
    output logic [memCtrlPkg::extAddrWidth-1:0] awaddr,
    output logic [7:0] awlen,
    output logic [1:0] awburst,
    input  wire rvalid,
    output logic rready,
    input  wire [memCtrlPkg::idWidth-1:0] rid,
    input  wire [memCtrlPkg::dataWidth-1:0] rdata,
    input  wire rlast,
    output logic rdReqValid,
    input  wire rdReqReady,
    output logic [memCtrlPkg::idWidth-1:0] rdReqId,
    output logic [memCtrlPkg::cacheAddrWidth-1:0] rdReqAddr,
    input  wire wBeatFire,
    input  wire [memCtrlPkg::idWidth-1:0] wBeatId,
    output logic fillValid,
    input  wire fillReady,
    output logic [memCtrlPkg::cacheAddrWidth-1:0] fillAddr,
    output logic [memCtrlPkg::dataWidth-1:0] fillData
);

    logic [memCtrlPkg::numSlots-1:0] slotValid;
    logic [memCtrlPkg::numSlots-1:0] slotNeedRead;
    // bit 0 is the cache read request, bit 1 the AW request
    logic [1:0] slotNeedWrite [memCtrlPkg::numSlots-1:0];
    memCtrlPkg::memCmd slotCmd [memCtrlPkg::numSlots-1:0];
    logic [memCtrlPkg::cacheAddrWidth-1:0] slotCacheAddr [memCtrlPkg::numSlots-1:0];
    logic [memCtrlPkg::extAddrWidth-1:0] slotExtAddr [memCtrlPkg::numSlots-1:0];
    logic [memCtrlPkg::extAddrWidth-1:0] slotOldAddr [memCtrlPkg::numSlots-1:0];
    logic [memCtrlPkg::progWidth-1:0] slotFillProg [memCtrlPkg::numSlots-1:0];
    logic [memCtrlPkg::progWidth-1:0] slotEvictProg [memCtrlPkg::numSlots-1:0];

    logic [memCtrlPkg::idWidth-1:0] enqIdx;
    logic freeValid;
    logic takeValid;
    memCtrlPkg::memCmd selCmd;
    logic [memCtrlPkg::cacheAddrWidth-1:0] selCacheAddr;
    logic [memCtrlPkg::extAddrWidth-1:0] selExtAddr;
    logic [memCtrlPkg::extAddrWidth-1:0] selOldAddr;
    logic [memCtrlPkg::idWidth-1:0] arIdx;
    logic [memCtrlPkg::idWidth-1:0] wrIdx;
    logic wrIdxValid;
    logic selHasEvict;

    assign slotBusy = slotValid;

    // first free slot
    always_comb begin
        enqIdx = '0;
        freeValid = 1'b0;
        for (int i = memCtrlPkg::numSlots - 1; i >= 0; i--) begin
            if (!slotValid[i]) begin
                enqIdx = i[memCtrlPkg::idWidth-1:0];
                freeValid = 1'b1;
            end
        end
    end

    // lowest requesting client wins, everybody waits without a free slot
    always_comb begin
        logic lowerReq;
        lowerReq = 1'b0;
        selCmd = memCtrlPkg::cmdNone;
        selCacheAddr = reqCacheAddr[0];
        selExtAddr = reqExtAddr[0];
        selOldAddr = reqOldAddr[0];
        for (int c = 0; c < memCtrlPkg::numClients; c++) begin
            stall[c] = !freeValid || (reqCmd[c] != memCtrlPkg::cmdNone && lowerReq);
            if (!lowerReq && reqCmd[c] != memCtrlPkg::cmdNone) begin
                selCmd = reqCmd[c];
                selCacheAddr = reqCacheAddr[c];
                selExtAddr = reqExtAddr[c];
                selOldAddr = reqOldAddr[c];
            end
            lowerReq = lowerReq || reqCmd[c] != memCtrlPkg::cmdNone;
        end
        takeValid = freeValid && selCmd != memCtrlPkg::cmdNone;
    end

    assign selHasEvict = selCmd == memCtrlPkg::cmdWriteback || selCmd == memCtrlPkg::cmdReplace;

    // read request only once the slot's write side is fully issued
    always_comb begin
        arIdx = '0;
        arvalid = 1'b0;
        for (int i = memCtrlPkg::numSlots - 1; i >= 0; i--) begin
            if (slotValid[i] && slotNeedRead[i] && slotNeedWrite[i] == 2'b00) begin
                arIdx = i[memCtrlPkg::idWidth-1:0];
                arvalid = 1'b1;
            end
        end
    end

    assign arid = arIdx;
    assign araddr = slotExtAddr[arIdx];
    assign arlen = memCtrlPkg::burstLen;
    assign arburst = memCtrlPkg::burstIncr;

    // a slot issued on only one side goes first, so both sides keep the same order
    always_comb begin
        wrIdx = '0;
        wrIdxValid = 1'b0;
        for (int i = memCtrlPkg::numSlots - 1; i >= 0; i--) begin
            if (slotValid[i] && slotNeedWrite[i] != 2'b00) begin
                wrIdx = i[memCtrlPkg::idWidth-1:0];
                wrIdxValid = 1'b1;
            end
        end
        for (int i = memCtrlPkg::numSlots - 1; i >= 0; i--) begin
            if (slotValid[i] && (slotNeedWrite[i] == 2'b01 || slotNeedWrite[i] == 2'b10)) begin
                wrIdx = i[memCtrlPkg::idWidth-1:0];
            end
        end
    end

    assign awvalid = wrIdxValid && slotNeedWrite[wrIdx][1];
    assign awid = wrIdx;
    assign awaddr = slotOldAddr[wrIdx];
    assign awlen = memCtrlPkg::burstLen;
    assign awburst = memCtrlPkg::burstIncr;
    assign rdReqValid = wrIdxValid && slotNeedWrite[wrIdx][0];
    assign rdReqId = wrIdx;
    assign rdReqAddr = slotCacheAddr[wrIdx];

    // R beats wait until the old word at that position has left on W
    assign fillValid = rvalid && slotValid[rid] && slotEvictProg[rid] > slotFillProg[rid];
    assign rready = fillValid && fillReady;
    assign fillAddr = {slotCacheAddr[rid][memCtrlPkg::cacheAddrWidth-1:memCtrlPkg::beatIdxWidth],
                       slotFillProg[rid][memCtrlPkg::beatIdxWidth-1:0]};
    assign fillData = rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= '0;
            slotNeedRead <= '0;
            for (int i = 0; i < memCtrlPkg::numSlots; i++) begin
                slotNeedWrite[i] <= 2'b00;
            end
        end else begin
            if (takeValid) begin
                slotValid[enqIdx] <= 1'b1;
                slotCmd[enqIdx] <= selCmd;
                slotCacheAddr[enqIdx] <= selCacheAddr;
                slotExtAddr[enqIdx] <= selExtAddr & memCtrlPkg::lineAlignMask;
                slotOldAddr[enqIdx] <= selOldAddr & memCtrlPkg::lineAlignMask;
                slotNeedRead[enqIdx] <= selCmd != memCtrlPkg::cmdWriteback;
                slotNeedWrite[enqIdx] <= {2{selHasEvict}};
                slotFillProg[enqIdx] <= '0;
                // nothing to evict means the fill is never held back
                slotEvictProg[enqIdx] <= selHasEvict ? '0 : memCtrlPkg::progFull;
            end
            if (arvalid && arready) begin
                slotNeedRead[arIdx] <= 1'b0;
            end
            if (rdReqValid && rdReqReady) begin
                slotNeedWrite[wrIdx][0] <= 1'b0;
            end
            if (awvalid && awready) begin
                slotNeedWrite[wrIdx][1] <= 1'b0;
            end
            if (rvalid && rready) begin
                slotFillProg[rid] <= slotFillProg[rid] + 1'b1;
                if (rlast) begin
                    slotValid[rid] <= 1'b0;
                end
            end
            if (wBeatFire) begin
                slotEvictProg[wBeatId] <= slotEvictProg[wBeatId] + 1'b1;
                // writeback alone is done with its last W beat
                if (slotCmd[wBeatId] == memCtrlPkg::cmdWriteback &&
                    slotEvictProg[wBeatId] == memCtrlPkg::progFull - 1'b1) begin
                    slotValid[wBeatId] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/cacheReadPort.sv
`timescale 1ns/100ps
`default_nettype none

module cacheReadPort (
    input  wire clk,
    input  wire rst,
    input  wire rdReqValid,
    output logic rdReqReady,
    input  wire [memCtrlPkg::idWidth-1:0] rdReqId,
    input  wire [memCtrlPkg::cacheAddrWidth-1:0] rdReqAddr,
    output logic wBeatFire,
    output logic [memCtrlPkg::idWidth-1:0] wBeatId,
    output logic wvalid,
    input  wire wready,
    output logic [memCtrlPkg::dataWidth-1:0] wdata,
    output logic [memCtrlPkg::dataWidth/8-1:0] wstrb,
    output logic wlast,
    output logic sramCe,
    output logic sramWe,
    output logic [memCtrlPkg::cacheAddrWidth-1:0] sramAddr,
    input  wire [memCtrlPkg::dataWidth-1:0] sramRdata,
    output logic cacheGrant,
    input  wire cacheWrCe,
    input  wire cacheWrWe,
    input  wire [memCtrlPkg::cacheAddrWidth-1:0] cacheWrAddr
);

    logic rdActive;
    logic [memCtrlPkg::beatIdxWidth-1:0] rdBeat;
    logic [memCtrlPkg::cacheAddrWidth-1:0] rdBase;
    logic [memCtrlPkg::idWidth-1:0] rdId;
    logic issue;
    logic pop;
    // beats read from the SRAM and not yet sent on W, in flight or buffered
    logic [1:0] resv;
    logic pendValid;
    logic pendLast;
    logic [memCtrlPkg::idWidth-1:0] pendId;
    logic [memCtrlPkg::dataWidth-1:0] bufData [0:1];
    logic [memCtrlPkg::idWidth-1:0] bufId [0:1];
    logic bufLast [0:1];
    logic [1:0] bufCount;
    logic wrPtr;
    logic rdPtr;

    assign rdReqReady = !rdActive;
    assign pop = wvalid && wready;
    assign issue = rdActive && (resv != 2'd2 || pop);

    // reads win the SRAM, the write port gets every idle cycle
    assign cacheGrant = !issue;
    assign sramCe = issue ? 1'b0 : cacheWrCe;
    assign sramWe = issue ? 1'b1 : cacheWrWe;
    assign sramAddr = issue ? {rdBase[memCtrlPkg::cacheAddrWidth-1:memCtrlPkg::beatIdxWidth], rdBeat}
                            : cacheWrAddr;

    assign wvalid = bufCount != 2'd0;
    assign wdata = bufData[rdPtr];
    assign wlast = bufLast[rdPtr];
    assign wstrb = '1;
    assign wBeatFire = pop;
    assign wBeatId = bufId[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rdActive <= 1'b0;
            pendValid <= 1'b0;
            resv <= 2'd0;
            bufCount <= 2'd0;
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
        end else begin
            if (rdReqValid && rdReqReady) begin
                rdActive <= 1'b1;
                rdBeat <= '0;
                rdBase <= rdReqAddr;
                rdId <= rdReqId;
            end else if (issue) begin
                rdBeat <= rdBeat + 1'b1;
                if (rdBeat == memCtrlPkg::beatIdxWidth'(memCtrlPkg::beatsPerLine - 1)) begin
                    rdActive <= 1'b0;
                end
            end
            // tag follows the read so the data lands with it a cycle later
            pendValid <= issue;
            pendId <= rdId;
            pendLast <= rdBeat == memCtrlPkg::beatIdxWidth'(memCtrlPkg::beatsPerLine - 1);
            if (pendValid) begin
                bufData[wrPtr] <= sramRdata;
                bufId[wrPtr] <= pendId;
                bufLast[wrPtr] <= pendLast;
                wrPtr <= !wrPtr;
            end
            if (pop) begin
                rdPtr <= !rdPtr;
            end
            bufCount <= bufCount + {1'b0, pendValid} - {1'b0, pop};
            resv <= resv + {1'b0, issue} - {1'b0, pop};
        end
    end

endmodule

`default_nettype wire

//--- source/cacheWritePort.sv
`timescale 1ns/100ps
`default_nettype none

module cacheWritePort (
    input  wire clk,
    input  wire rst,
    input  wire fillValid,
    output logic fillReady,
    input  wire [memCtrlPkg::cacheAddrWidth-1:0] fillAddr,
    input  wire [memCtrlPkg::dataWidth-1:0] fillData,
    input  wire cacheGrant,
    output logic cacheWrCe,
    output logic cacheWrWe,
    output logic [memCtrlPkg::cacheAddrWidth-1:0] cacheWrAddr,
    output logic [memCtrlPkg::dataWidth-1:0] sramWdata
);

    logic holdValid;
    logic [memCtrlPkg::cacheAddrWidth-1:0] holdAddr;
    logic [memCtrlPkg::dataWidth-1:0] holdData;
    logic drain;

    // held beat goes into the SRAM in any cycle the read side leaves free
    assign drain = holdValid && cacheGrant;
    assign fillReady = !holdValid || drain;

    assign cacheWrCe = !holdValid;
    assign cacheWrWe = !holdValid;
    assign cacheWrAddr = holdAddr;
    assign sramWdata = holdData;

    always_ff @(posedge clk) begin
        if (rst) begin
            holdValid <= 1'b0;
        end else if (fillValid && fillReady) begin
            holdValid <= 1'b1;
            holdAddr <= fillAddr;
            holdData <= fillData;
        end else if (drain) begin
            holdValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/memController.sv
`timescale 1ns/100ps
`default_nettype none

module memController (
    input  wire clk,
    input  wire rst,
    input  wire memCtrlPkg::memCmd reqCmd [memCtrlPkg::numClients-1:0],
    input  wire [memCtrlPkg::cacheAddrWidth-1:0] reqCacheAddr [memCtrlPkg::numClients-1:0],
    input  wire [memCtrlPkg::extAddrWidth-1:0] reqExtAddr [memCtrlPkg::numClients-1:0],
    input  wire [memCtrlPkg::extAddrWidth-1:0] reqOldAddr [memCtrlPkg::numClients-1:0],
    output wire [memCtrlPkg::numClients-1:0] stall,
    output wire [memCtrlPkg::numSlots-1:0] slotBusy,
    output wire arvalid,
    input  wire arready,
    output wire [memCtrlPkg::idWidth-1:0] arid,
    output wire [memCtrlPkg::extAddrWidth-1:0] araddr,
    output wire [7:0] arlen,
    output wire [1:0] arburst,
    input  wire rvalid,
    output wire rready,
    input  wire [memCtrlPkg::idWidth-1:0] rid,
    input  wire [memCtrlPkg::dataWidth-1:0] rdata,
    input  wire rlast,
    output wire awvalid,
    input  wire awready,
    output wire [memCtrlPkg::idWidth-1:0] awid,
    output wire [memCtrlPkg::extAddrWidth-1:0] awaddr,
    output wire [7:0] awlen,
    output wire [1:0] awburst,
    output wire wvalid,
    input  wire wready,
    output wire [memCtrlPkg::dataWidth-1:0] wdata,
    output wire [memCtrlPkg::dataWidth/8-1:0] wstrb,
    output wire wlast,
    output wire bready,
    output wire sramCe,
    output wire sramWe,
    output wire [memCtrlPkg::cacheAddrWidth-1:0] sramAddr,
    output wire [memCtrlPkg::dataWidth-1:0] sramWdata,
    input  wire [memCtrlPkg::dataWidth-1:0] sramRdata
);

    // line read requests from the table to the read port
    wire rdReqValid;
    wire rdReqReady;
    wire [memCtrlPkg::idWidth-1:0] rdReqId;
    wire [memCtrlPkg::cacheAddrWidth-1:0] rdReqAddr;
    wire wBeatFire;
    wire [memCtrlPkg::idWidth-1:0] wBeatId;

    // fill beats and the shared SRAM port
    wire fillValid;
    wire fillReady;
    wire [memCtrlPkg::cacheAddrWidth-1:0] fillAddr;
    wire [memCtrlPkg::dataWidth-1:0] fillData;
    wire cacheGrant;
    wire cacheWrCe;
    wire cacheWrWe;
    wire [memCtrlPkg::cacheAddrWidth-1:0] cacheWrAddr;

    // write responses carry nothing the table needs
    assign bready = 1'b1;

    transferTable table0 (.*);

    cacheReadPort readPort (.*);

    cacheWritePort writePort (.*);

endmodule

`default_nettype wire

//--- verif/memControllerTb.sv
`timescale 1ns/100ps
`default_nettype none

module memControllerTb;

    logic clk = 1'b0;
    logic rst = 1'b1;
    memCtrlPkg::memCmd reqCmd [memCtrlPkg::numClients-1:0] = '{default: memCtrlPkg::cmdNone};
    logic [7:0] reqCacheAddr [memCtrlPkg::numClients-1:0] = '{default: '0};
    logic [31:0] reqExtAddr [memCtrlPkg::numClients-1:0] = '{default: '0};
    logic [31:0] reqOldAddr [memCtrlPkg::numClients-1:0] = '{default: '0};
    wire [1:0] stall;
    wire [3:0] slotBusy;
    wire arvalid, rready, awvalid, wvalid, wlast, bready, sramCe, sramWe;
    wire [1:0] arid, awid, arburst, awburst;
    wire [31:0] araddr, awaddr, wdata, sramWdata;
    wire [7:0] arlen, awlen, sramAddr;
    wire [3:0] wstrb;
    logic arready = 1'b0;
    logic awready = 1'b0;
    logic wready = 1'b0;
    logic rvalid = 1'b0;
    logic rlast = 1'b0;
    logic [1:0] rid = '0;
    logic [31:0] rdata = '0;
    logic [31:0] sramRdata = '0;

    // SRAM model and AXI memory model state
    logic [31:0] sramMem [0:255];
    logic [31:0] memStore [logic [31:0]];
    logic [31:0] lcgState = 32'd67;
    logic [1:0] arIdQ [$];
    logic [31:0] arAddrQ [$];
    logic [31:0] awAddrQ [$];
    logic [31:0] wDataQ [$];
    int rBeat = 0;
    int wCount = 0;

    // pattern entries
    int numEnt = 0;
    logic [31:0] entBatch [0:15];
    logic [31:0] entClient [0:15];
    logic [31:0] entCmd [0:15];
    logic [31:0] entCache [0:15];
    logic [31:0] entExt [0:15];
    logic [31:0] entOld [0:15];
    logic [31:0] entExp [0:15][0:3];
    logic [31:0] snapOld [0:15][0:3];
    int errorCount = 0;
    int testsRun = 0;
    int testsBad = 0;
    logic timedOut = 1'b0;

    memController UUT (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] memRead(input logic [31:0] a);
        if (memStore.exists(a)) begin
            return memStore[a];
        end
        return a ^ 32'hA5A50000;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errorCount++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // SRAM writes with ce and we low and returns read data one cycle later
    always @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 256; k++) begin
                sramMem[k] <= k * 32'h01010101;
            end
        end else if (!sramCe && !sramWe) begin
            sramMem[sramAddr] <= sramWdata;
        end else if (!sramCe) begin
            sramRdata <= sramMem[sramAddr];
        end
    end

    // AXI memory with random ready and valid gaps
    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            arIdQ.delete();
            arAddrQ.delete();
            awAddrQ.delete();
            wDataQ.delete();
            memStore.delete();
            rBeat = 0;
            wCount = 0;
        end else begin
            lcgState = lcgNext(lcgState);
            if (arvalid && arready) begin
                checkValue("arlen", 32'(arlen), 32'(memCtrlPkg::burstLen));
                checkValue("arburst", 32'(arburst), 32'd1);
                // the ID names a slot that holds a transfer
                checkValue("slotBusy[arid]", 32'(slotBusy[arid]), 32'd1);
                arIdQ.push_back(arid);
                arAddrQ.push_back(araddr);
            end
            if (awvalid && awready) begin
                checkValue("awlen", 32'(awlen), 32'(memCtrlPkg::burstLen));
                checkValue("awburst", 32'(awburst), 32'd1);
                checkValue("slotBusy[awid]", 32'(slotBusy[awid]), 32'd1);
                awAddrQ.push_back(awaddr);
            end
            if (wvalid && wready) begin
                checkValue("wlast", 32'(wlast), 32'(wCount == 3));
                checkValue("wstrb", 32'(wstrb), 32'hF);
                checkValue("bready", 32'(bready), 32'd1);
                wDataQ.push_back(wdata);
                wCount = (wCount == 3) ? 0 : wCount + 1;
            end
            // a burst is stored once its address and all four beats are in
            while (awAddrQ.size() > 0 && wDataQ.size() >= 4) begin
                for (int k = 0; k < 4; k++) begin
                    memStore[awAddrQ[0] + 32'(4 * k)] = wDataQ.pop_front();
                end
                void'(awAddrQ.pop_front());
            end
            if (rvalid && rready) begin
                rBeat++;
                if (rlast) begin
                    void'(arIdQ.pop_front());
                    void'(arAddrQ.pop_front());
                    rBeat = 0;
                end
            end
            if (rvalid && !rready) begin
                rvalid <= 1'b1;
            end else if (arIdQ.size() > 0 && (lcgState[22] || lcgState[21])) begin
                rvalid <= 1'b1;
                rid <= arIdQ[0];
                rdata <= memRead(arAddrQ[0] + 32'(4 * rBeat));
                rlast <= rBeat == 3;
            end else begin
                rvalid <= 1'b0;
            end
            arready <= lcgState[28] || lcgState[27];
            awready <= lcgState[26] || lcgState[25];
            wready <= lcgState[24] || lcgState[23];
        end
    end

    task automatic checkResetState();
        checkValue("arvalid", 32'(arvalid), 32'd0);
        checkValue("awvalid", 32'(awvalid), 32'd0);
        checkValue("wvalid", 32'(wvalid), 32'd0);
        checkValue("slotBusy", 32'(slotBusy), 32'd0);
        checkValue("sramCe", 32'(sramCe), 32'd1);
    endtask

    task automatic driveClient(input int c, input int idx);
        if (idx < 0) begin
            reqCmd[c] <= memCtrlPkg::cmdNone;
        end else begin
            reqCmd[c] <= memCtrlPkg::memCmd'(entCmd[idx][1:0]);
            reqCacheAddr[c] <= entCache[idx][7:0];
            reqExtAddr[c] <= entExt[idx];
            reqOldAddr[c] <= entOld[idx];
        end
    endtask

    task automatic runBatch(input int b);
        int pend0 [$];
        int pend1 [$];
        int cycles;
        int startErr;
        startErr = errorCount;
        for (int i = 0; i < numEnt; i++) begin
            if (entBatch[i] == 32'(b)) begin
                for (int k = 0; k < 4; k++) begin
                    snapOld[i][k] = sramMem[entCache[i] + 32'(k)];
                end
                if (entClient[i] == 0) pend0.push_back(i);
                else pend1.push_back(i);
            end
        end
        @(posedge clk);
        driveClient(0, pend0.size() > 0 ? pend0[0] : -1);
        driveClient(1, pend1.size() > 0 ? pend1[0] : -1);
        cycles = 0;
        while ((pend0.size() > 0 || pend1.size() > 0) && cycles < 400) begin
            @(posedge clk);
            cycles++;
            checkValue("stall[0]", 32'(stall[0]), 32'(&slotBusy));
            // lower index client wins a shared cycle
            if (reqCmd[0] != memCtrlPkg::cmdNone && reqCmd[1] != memCtrlPkg::cmdNone) begin
                checkValue("stall[1]", 32'(stall[1]), 32'd1);
            end
            if (reqCmd[0] != memCtrlPkg::cmdNone && !stall[0]) void'(pend0.pop_front());
            if (reqCmd[1] != memCtrlPkg::cmdNone && !stall[1]) void'(pend1.pop_front());
            driveClient(0, pend0.size() > 0 ? pend0[0] : -1);
            driveClient(1, pend1.size() > 0 ? pend1[0] : -1);
        end
        // idle means no slot, no held fill beat and no W beat left
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!(slotBusy == 0 && sramCe && !wvalid) && cycles < 2000);
        if (cycles >= 2000 || pend0.size() > 0 || pend1.size() > 0) begin
            $display("timeout: transfers of test %0d never finished", b);
            errorCount++;
            timedOut = 1'b1;
        end
        for (int i = 0; i < numEnt; i++) begin
            if (entBatch[i] == 32'(b)) begin
                for (int k = 0; k < 4; k++) begin
                    if (entCmd[i] == 2) begin
                        checkValue($sformatf("mem[%h]", entOld[i] + 32'(4 * k)),
                                   memRead(entOld[i] + 32'(4 * k)), entExp[i][k]);
                    end else begin
                        checkValue($sformatf("sram[%h]", entCache[i] + 32'(k)),
                                   sramMem[entCache[i] + 32'(k)], entExp[i][k]);
                    end
                    if (entCmd[i] == 3) begin
                        checkValue($sformatf("mem[%h]", entOld[i] + 32'(4 * k)),
                                   memRead(entOld[i] + 32'(4 * k)), snapOld[i][k]);
                    end
                end
            end
        end
        testsRun++;
        if (errorCount != startErr) testsBad++;
        $display("test %0d done with %0d errors", b, errorCount - startErr);
    endtask

    initial begin
        int fd;
        int cnt;
        string line;
        logic [31:0] v [0:9];
        fd = $fopen("verif/memControllerPatterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            errorCount++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != 8'h23 && numEnt < 16) begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                                  v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                    if (cnt == 10) begin
                        entBatch[numEnt] = v[0];
                        entClient[numEnt] = v[1];
                        entCmd[numEnt] = v[2];
                        entCache[numEnt] = v[3];
                        entExt[numEnt] = v[4];
                        entOld[numEnt] = v[5];
                        for (int k = 0; k < 4; k++) entExp[numEnt][k] = v[6 + k];
                        numEnt++;
                    end
                end
            end
            $fclose(fd);
        end
        // registers are still unknown before the first reset edge
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i > 0) checkResetState();
        end
        rst <= 1'b0;
        @(posedge clk);
        checkResetState();
        testsRun++;
        if (errorCount != 0) testsBad++;
        $display("test 0 done with %0d errors", errorCount);
        for (int b = 1; b <= 6; b++) begin
            if (!timedOut) runBatch(b);
        end
        $display("tests run %0d, tests with errors %0d, failed checks %0d",
                 testsRun, testsBad, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/memControllerPatterns.txt
# test client cmd(1 fill 2 writeback 3 replace) cacheAddr extAddr oldAddr, all hex
# then the four expected words of the destination line
1 0 1 10 1000 0 A5A51000 A5A51004 A5A51008 A5A5100C
2 0 2 20 0 2000 20202020 21212121 22222222 23232323
3 1 3 30 3000 4000 A5A53000 A5A53004 A5A53008 A5A5300C
4 0 1 40 5000 0 A5A55000 A5A55004 A5A55008 A5A5500C
4 1 1 44 5010 0 A5A55010 A5A55014 A5A55018 A5A5501C
5 0 1 50 6000 0 A5A56000 A5A56004 A5A56008 A5A5600C
5 0 1 54 6010 0 A5A56010 A5A56014 A5A56018 A5A5601C
5 0 1 58 6020 0 A5A56020 A5A56024 A5A56028 A5A5602C
5 0 1 5C 6030 0 A5A56030 A5A56034 A5A56038 A5A5603C
5 0 1 60 6040 0 A5A56040 A5A56044 A5A56048 A5A5604C
6 0 2 10 0 7000 A5A51000 A5A51004 A5A51008 A5A5100C

//--- memController.f
source/memCtrlPkg.sv
source/transferTable.sv
source/cacheReadPort.sv
source/cacheWritePort.sv
source/memController.sv
verif/memControllerTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the testbench, then decide on the log
verilator --binary --timing --assert -Wno-fatal --top-module memControllerTb \
    -f memController.f -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/VmemControllerTb > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
if grep -q "test failed" sim.log; then
    exit 1
fi
grep -q "test passed" sim.log || exit 1
